//--- core_pkg.sv
package core_pkg;

	// lanes in decode, exec and writeback
	localparam int ISSUE_NUM = 2;

	typedef logic [4:0]  reg_addr_t;
	typedef logic [31:0] uint32_t;

	// up to two credits per cycle
	typedef logic [1:0] credit_t;

	// major opcode in instr[31:26]
	typedef enum logic [5:0] {
		OPC_SPECIAL = 6'h00,
		OPC_ADDIU   = 6'h09,
		OPC_ORI     = 6'h0d,
		OPC_LUI     = 6'h0f
	} opcode_t;

	// SPECIAL funct in instr[5:0]
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a,
		FN_SLTU = 6'h2b
	} funct_t;

	typedef enum logic [3:0] {
		OP_NOP,
		OP_ADDU,
		OP_SUBU,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_NOR,
		OP_SLT,
		OP_SLTU,
		OP_SLL,
		OP_SRL,
		OP_ADDIU,
		OP_ORI,
		OP_LUI
	} alu_op_t;

	typedef struct packed {
		logic    valid;
		uint32_t instr;
	} fetch_entry_t;

	// one issued instruction with resolved operands
	typedef struct packed {
		logic      valid;
		alu_op_t   op;
		reg_addr_t rd;
		uint32_t   opa;
		uint32_t   opb;
		logic [4:0] shamt;
	} pipeline_decode_t;

	// exec result as held in EX/WB and shown on retire
	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		uint32_t   wdata;
	} pipeline_exec_t;

endpackage

//--- instr_queue.sv
module instr_queue #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   in_valid,
	input  core_pkg::uint32_t      in_instr,
	input  core_pkg::credit_t      issue_num,
	output core_pkg::fetch_entry_t [core_pkg::ISSUE_NUM-1:0] head_entries,
	output core_pkg::credit_t      credit_return
);

	import core_pkg::*;

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [CNT_W-1:0] count_t;

	uint32_t mem [QUEUE_DEPTH];
	ptr_t    rptr, wptr;
	count_t  count;

	// pointer advance with wrap for any depth
	function automatic ptr_t wrap_add(ptr_t p, int unsigned n);
		int unsigned s;
		s = int'(p) + n;
		if (s >= QUEUE_DEPTH)
			s = s - QUEUE_DEPTH;
		return ptr_t'(s);
	endfunction

	always_ff @(posedge clk) begin
		if (in_valid)
			mem[wptr] <= in_instr;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rptr          <= '0;
			wptr          <= '0;
			count         <= '0;
			credit_return <= '0;
		end else begin
			if (in_valid)
				wptr <= wrap_add(wptr, 1);
			rptr          <= wrap_add(rptr, issue_num);
			count         <= count + count_t'(in_valid) - count_t'(issue_num);
			// each popped entry frees one slot at the sender
			credit_return <= issue_num;
		end
	end

	assign head_entries[0].valid = (count > 0);
	assign head_entries[0].instr = mem[rptr];
	assign head_entries[1].valid = (count > 1);
	assign head_entries[1].instr = mem[wrap_add(rptr, 1)];

endmodule

//--- regfile.sv
module regfile #(
	parameter int REG_NUM     = 32,
	parameter int READ_PORTS  = 4,
	parameter int WRITE_PORTS = 2,
	parameter bit ZERO_KEEP   = 1
) (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic               [WRITE_PORTS-1:0]   we,
	input  core_pkg::reg_addr_t [WRITE_PORTS-1:0]  waddr,
	input  core_pkg::uint32_t  [WRITE_PORTS-1:0]   wdata,
	input  core_pkg::reg_addr_t [READ_PORTS-1:0]   raddr,
	output core_pkg::uint32_t  [READ_PORTS-1:0]    rdata
);

	import core_pkg::*;

	uint32_t [REG_NUM-1:0] regs;

	// later ports overwrite earlier ones on the same address
	always_ff @(posedge clk) begin
		if (rst) begin
			regs <= '0;
		end else begin
			for (int w = 0; w < WRITE_PORTS; w++) begin
				if (we[w] && !(ZERO_KEEP && waddr[w] == '0))
					regs[waddr[w]] <= wdata[w];
			end
		end
	end

	always_comb begin
		for (int r = 0; r < READ_PORTS; r++) begin
			if (ZERO_KEEP && raddr[r] == '0)
				rdata[r] = '0;
			else
				rdata[r] = regs[raddr[r]];
		end
	end

endmodule

//--- decode_and_issue.sv
module decode_and_issue (
	input  core_pkg::fetch_entry_t     [core_pkg::ISSUE_NUM-1:0]   fetch_entry,
	input  core_pkg::pipeline_exec_t   [core_pkg::ISSUE_NUM-1:0]   pipeline_exec,
	input  core_pkg::pipeline_exec_t   [core_pkg::ISSUE_NUM-1:0]   pipeline_wb,
	output core_pkg::reg_addr_t        [2*core_pkg::ISSUE_NUM-1:0] reg_raddr,
	input  core_pkg::uint32_t          [2*core_pkg::ISSUE_NUM-1:0] reg_rdata,
	output core_pkg::credit_t                                      issue_num,
	output core_pkg::pipeline_decode_t [core_pkg::ISSUE_NUM-1:0]   pipeline_decode
);

	import core_pkg::*;

	typedef struct packed {
		alu_op_t    op;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic       uses_rs;
		logic       uses_rt;
		logic       use_imm;
		uint32_t    imm;
		logic [4:0] shamt;
	} decoded_t;

	decoded_t dec [ISSUE_NUM];
	logic     dep;

	function automatic decoded_t decode_instr(uint32_t instr);
		decoded_t d;
		d       = '0;
		d.op    = OP_NOP;
		d.rs    = instr[25:21];
		d.rt    = instr[20:16];
		d.shamt = instr[10:6];
		case (instr[31:26])
			OPC_SPECIAL: begin
				case (instr[5:0])
					FN_SLL:  d.op = OP_SLL;
					FN_SRL:  d.op = OP_SRL;
					FN_ADDU: d.op = OP_ADDU;
					FN_SUBU: d.op = OP_SUBU;
					FN_AND:  d.op = OP_AND;
					FN_OR:   d.op = OP_OR;
					FN_XOR:  d.op = OP_XOR;
					FN_NOR:  d.op = OP_NOR;
					FN_SLT:  d.op = OP_SLT;
					FN_SLTU: d.op = OP_SLTU;
					default: d.op = OP_NOP;
				endcase
				d.rd      = instr[15:11];
				// shifts take rt and sa only
				d.uses_rs = (d.op != OP_SLL) && (d.op != OP_SRL);
				d.uses_rt = 1'b1;
			end
			OPC_ADDIU: begin
				d.op      = OP_ADDIU;
				d.rd      = instr[20:16];
				d.uses_rs = 1'b1;
				d.use_imm = 1'b1;
				d.imm     = {{16{instr[15]}}, instr[15:0]};
			end
			OPC_ORI: begin
				d.op      = OP_ORI;
				d.rd      = instr[20:16];
				d.uses_rs = 1'b1;
				d.use_imm = 1'b1;
				d.imm     = {16'h0, instr[15:0]};
			end
			OPC_LUI: begin
				d.op      = OP_LUI;
				d.rd      = instr[20:16];
				d.use_imm = 1'b1;
				d.imm     = {16'h0, instr[15:0]};
			end
			default: ;
		endcase
		// unknown encodings retire as nop to r0
		if (d.op == OP_NOP) begin
			d.rd      = '0;
			d.uses_rs = 1'b0;
			d.uses_rt = 1'b0;
		end
		return d;
	endfunction

	// youngest producer wins, so later checks override
	function automatic uint32_t forward_operand(
		reg_addr_t                       addr,
		uint32_t                         rf_value,
		pipeline_exec_t [ISSUE_NUM-1:0]  ex,
		pipeline_exec_t [ISSUE_NUM-1:0]  wb
	);
		uint32_t v;
		v = rf_value;
		for (int i = 0; i < ISSUE_NUM; i++) begin
			if (wb[i].valid && wb[i].rd != '0 && wb[i].rd == addr)
				v = wb[i].wdata;
		end
		for (int i = 0; i < ISSUE_NUM; i++) begin
			if (ex[i].valid && ex[i].rd != '0 && ex[i].rd == addr)
				v = ex[i].wdata;
		end
		return v;
	endfunction

	always_comb begin
		for (int i = 0; i < ISSUE_NUM; i++) begin
			dec[i]             = decode_instr(fetch_entry[i].instr);
			reg_raddr[2*i]     = dec[i].rs;
			reg_raddr[2*i + 1] = dec[i].rt;
		end
	end

	// second slot waits if it reads what the first one writes
	assign dep = (dec[0].rd != '0) &&
		((dec[1].uses_rs && dec[1].rs == dec[0].rd) ||
		 (dec[1].uses_rt && dec[1].rt == dec[0].rd));

	always_comb begin
		if (!fetch_entry[0].valid)
			issue_num = 2'd0;
		else if (!fetch_entry[1].valid || dep)
			issue_num = 2'd1;
		else
			issue_num = 2'd2;
	end

	always_comb begin
		for (int i = 0; i < ISSUE_NUM; i++) begin
			pipeline_decode[i].valid = (issue_num > i);
			pipeline_decode[i].op    = dec[i].op;
			pipeline_decode[i].rd    = dec[i].rd;
			pipeline_decode[i].shamt = dec[i].shamt;
			if (dec[i].uses_rs)
				pipeline_decode[i].opa = forward_operand(dec[i].rs, reg_rdata[2*i],
					pipeline_exec, pipeline_wb);
			else
				pipeline_decode[i].opa = '0;
			if (dec[i].use_imm)
				pipeline_decode[i].opb = dec[i].imm;
			else if (dec[i].uses_rt)
				pipeline_decode[i].opb = forward_operand(dec[i].rt, reg_rdata[2*i + 1],
					pipeline_exec, pipeline_wb);
			else
				pipeline_decode[i].opb = '0;
		end
	end

endmodule

//--- instr_exec.sv
module instr_exec (
	input  core_pkg::pipeline_decode_t data,
	output core_pkg::pipeline_exec_t   result
);

	import core_pkg::*;

	uint32_t alu_out;

	always_comb begin
		case (data.op)
			OP_ADDU,
			OP_ADDIU: alu_out = data.opa + data.opb;
			OP_SUBU:  alu_out = data.opa - data.opb;
			OP_AND:   alu_out = data.opa & data.opb;
			OP_OR,
			OP_ORI:   alu_out = data.opa | data.opb;
			OP_XOR:   alu_out = data.opa ^ data.opb;
			OP_NOR:   alu_out = ~(data.opa | data.opb);
			OP_SLT:   alu_out = {31'h0, $signed(data.opa) < $signed(data.opb)};
			OP_SLTU:  alu_out = {31'h0, data.opa < data.opb};
			OP_SLL:   alu_out = data.opb << data.shamt;
			OP_SRL:   alu_out = data.opb >> data.shamt;
			// immediate sits in the low half of opb
			OP_LUI:   alu_out = {data.opb[15:0], 16'h0};
			default:  alu_out = '0;
		endcase
	end

	always_comb begin
		result.valid = data.valid;
		if (!data.valid || data.op == OP_NOP) begin
			result.rd    = '0;
			result.wdata = '0;
		end else begin
			result.rd    = data.rd;
			result.wdata = alu_out;
		end
	end

endmodule

//--- cpu_core.sv
module cpu_core #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     instr_valid,
	input  core_pkg::uint32_t        instr,
	output core_pkg::credit_t        credit_return,
	output core_pkg::pipeline_exec_t [core_pkg::ISSUE_NUM-1:0] retire
);

	import core_pkg::*;

	localparam int REG_NUM     = 32;
	localparam int READ_PORTS  = 2 * ISSUE_NUM;
	localparam int WRITE_PORTS = ISSUE_NUM;
	localparam bit ZERO_KEEP   = 1'b1;

	fetch_entry_t     [ISSUE_NUM-1:0] head_entries;
	credit_t                          issue_num;

	logic             [WRITE_PORTS-1:0] reg_we;
	reg_addr_t        [WRITE_PORTS-1:0] reg_waddr;
	uint32_t          [WRITE_PORTS-1:0] reg_wdata;
	reg_addr_t        [READ_PORTS-1:0]  reg_raddr;
	uint32_t          [READ_PORTS-1:0]  reg_rdata;

	pipeline_decode_t [ISSUE_NUM-1:0] pipeline_decode, pipeline_decode_d;
	pipeline_exec_t   [ISSUE_NUM-1:0] pipeline_exec, pipeline_wb;

	instr_queue #(
		.QUEUE_DEPTH ( QUEUE_DEPTH )
	) instr_queue_inst (
		.clk,
		.rst,
		.in_valid      ( instr_valid   ),
		.in_instr      ( instr         ),
		.issue_num     ( issue_num     ),
		.head_entries  ( head_entries  ),
		.credit_return ( credit_return )
	);

	regfile #(
		.REG_NUM     ( REG_NUM     ),
		.READ_PORTS  ( READ_PORTS  ),
		.WRITE_PORTS ( WRITE_PORTS ),
		.ZERO_KEEP   ( ZERO_KEEP   )
	) regfile_inst (
		.clk,
		.rst,
		.we    ( reg_we    ),
		.waddr ( reg_waddr ),
		.wdata ( reg_wdata ),
		.raddr ( reg_raddr ),
		.rdata ( reg_rdata )
	);

	decode_and_issue decode_issue_inst (
		.fetch_entry     ( head_entries    ),
		.pipeline_exec   ( pipeline_exec   ),
		.pipeline_wb     ( pipeline_wb     ),
		.reg_raddr       ( reg_raddr       ),
		.reg_rdata       ( reg_rdata       ),
		.issue_num       ( issue_num       ),
		.pipeline_decode ( pipeline_decode )
	);

	// ID/EX
	always_ff @(posedge clk) begin
		if (rst)
			pipeline_decode_d <= '0;
		else
			pipeline_decode_d <= pipeline_decode;
	end

	for (genvar i = 0; i < ISSUE_NUM; i++) begin : gen_exec
		instr_exec exec_inst (
			.data   ( pipeline_decode_d[i] ),
			.result ( pipeline_exec[i]     )
		);
	end

	// EX/WB never stalls once issued
	always_ff @(posedge clk) begin
		if (rst)
			pipeline_wb <= '0;
		else
			pipeline_wb <= pipeline_exec;
	end

	// lane 1 is the higher write port and wins
	for (genvar i = 0; i < ISSUE_NUM; i++) begin : gen_write_back
		assign reg_we[i]    = pipeline_wb[i].valid && pipeline_wb[i].rd != '0;
		assign reg_waddr[i] = pipeline_wb[i].rd;
		assign reg_wdata[i] = pipeline_wb[i].wdata;
	end

	assign retire = pipeline_wb;

endmodule

//--- tb_cpu_core.sv
module tb_cpu_core;

	timeunit 1ns;
	timeprecision 1ps;

	import core_pkg::*;

	localparam int    QUEUE_DEPTH = 8;
	localparam int    MAX_INSTR   = 64;
	localparam string STIM_FILE   = "cpu_stim.txt";

	logic    clk;
	logic    rst;
	logic    instr_valid;
	uint32_t instr;
	credit_t credit_return;
	pipeline_exec_t [ISSUE_NUM-1:0] retire;

	// each instruction takes three words for word, rd and value
	uint32_t     stim_mem [3*MAX_INSTR];
	int          num_instr;
	int          credits;
	int          sent;
	int          returned;
	int          ret_idx;
	int          cycles;
	int          cycle_limit;
	int          value_errors;
	int          other_errors;
	logic [31:0] lfsr_state;

	cpu_core #(
		.QUEUE_DEPTH ( QUEUE_DEPTH )
	) dut_i (
		.clk,
		.rst,
		.instr_valid,
		.instr,
		.credit_return,
		.retire
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic draw_bits(input int n, output int v);
		v = 0;
		for (int b = 0; b < n; b++) begin
			v = (v << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// rd column above 31 means no line was loaded there
	task automatic load_stim();
		for (int i = 0; i < 3*MAX_INSTR; i++)
			stim_mem[i] = 32'hbad0_0000 + 32'(i);
		$readmemh(STIM_FILE, stim_mem);
		num_instr = 0;
		while (num_instr < MAX_INSTR && stim_mem[3*num_instr + 1] < 32)
			num_instr++;
	endtask

	task automatic take_credits();
		credits  += int'(credit_return);
		returned += int'(credit_return);
		assert (credits <= QUEUE_DEPTH) else begin
			other_errors++;
			$display("credit counter went above the queue depth: %0d", credits);
		end
	endtask

	task automatic check_retire(input pipeline_exec_t r);
		string      name;
		logic [4:0] exp_rd;
		uint32_t    exp_val;
		assert (ret_idx < num_instr) else begin
			other_errors++;
			$display("extra retire after the last instruction: rd %0d value %h", r.rd, r.wdata);
		end
		if (ret_idx < num_instr) begin
			name    = $sformatf("instr_%0d (%h)", ret_idx, stim_mem[3*ret_idx]);
			exp_rd  = stim_mem[3*ret_idx + 1][4:0];
			exp_val = stim_mem[3*ret_idx + 2];
			assert (r.rd == exp_rd) else begin
				value_errors++;
				$display("Fail %s rd: expected %0d, actual %0d", name, exp_rd, r.rd);
			end
			assert (r.wdata == exp_val) else begin
				value_errors++;
				$display("Fail %s value: expected %h, actual %h", name, exp_val, r.wdata);
			end
		end
		ret_idx++;
	endtask

	task automatic report_counts();
		$display("errors: %0d value mismatches, %0d other", value_errors, other_errors);
	endtask

	// lane 0 is the older retire
	always @(negedge clk) begin
		for (int l = 0; l < ISSUE_NUM; l++) begin
			if (retire[l].valid)
				check_retire(retire[l]);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: not all instructions retired within %0d cycles", cycle_limit);
			report_counts();
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		int gap;
		rst          = 1'b1;
		instr_valid  = 1'b0;
		instr        = '0;
		lfsr_state   = 32'hf4fd_f7e2;
		credits      = QUEUE_DEPTH;
		sent         = 0;
		returned     = 0;
		ret_idx      = 0;
		cycles       = 0;
		value_errors = 0;
		other_errors = 0;
		gap          = 0;
		load_stim();
		cycle_limit = num_instr * 4 + 50;
		assert (num_instr > 0) else begin
			other_errors++;
			$display("no instructions found in %s", STIM_FILE);
		end

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		assert (credit_return == 0 && !retire[0].valid && !retire[1].valid) else begin
			other_errors++;
			$display("outputs not idle after reset");
		end

		while (sent < num_instr) begin
			@(negedge clk);
			take_credits();
			instr_valid = 1'b0;
			if (gap > 0) begin
				gap--;
			end else if (credits > 0) begin
				instr_valid = 1'b1;
				instr       = stim_mem[3*sent];
				credits--;
				sent++;
				draw_bits(2, gap);
			end
		end
		@(negedge clk);
		take_credits();
		instr_valid = 1'b0;

		while (ret_idx < num_instr || credits < QUEUE_DEPTH) begin
			@(negedge clk);
			take_credits();
		end
		// a few idle cycles to catch stray retires or credits
		repeat (4) begin
			@(negedge clk);
			take_credits();
		end

		assert (credits == QUEUE_DEPTH) else begin
			other_errors++;
			$display("credits not back to %0d at the end: %0d", QUEUE_DEPTH, credits);
		end
		assert (returned == sent) else begin
			other_errors++;
			$display("returned %0d credits for %0d instructions sent", returned, sent);
		end
		report_counts();
		if (value_errors == 0 && other_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- cpu_stim.txt
// columns: instruction word, expected retire rd, expected retire value (all hex)
// rd 00 with value 00000000 is an unsupported encoding retiring as a nop
24010005 01 00000005  // addiu r1, r0, 5
2402fffd 02 fffffffd  // addiu r2, r0, -3
00221821 03 00000002  // addu r3, r1, r2
00222023 04 00000008  // subu r4, r1, r2
3c051234 05 12340000  // lui r5, 0x1234
34a55678 05 12345678  // ori r5, r5, 0x5678
00a43024 06 00000008  // and r6, r5, r4
00243825 07 0000000d  // or r7, r1, r4
00a24026 08 edcba985  // xor r8, r5, r2
00244827 09 fffffff2  // nor r9, r1, r4
0041502a 0a 00000001  // slt r10, r2, r1
0041582b 0b 00000000  // sltu r11, r2, r1
00056100 0c 23456780  // sll r12, r5, 4
00026a02 0d 00ffffff  // srl r13, r2, 8
24200007 00 0000000c  // addiu r0, r1, 7
00017021 0e 00000005  // addu r14, r0, r1
8c220000 00 00000000  // lw, unsupported
25cf0001 0f 00000006  // addiu r15, r14, 1
01ef7821 0f 0000000c  // addu r15, r15, r15
01ee8023 10 00000007  // subu r16, r15, r14
020f882a 11 00000001  // slt r17, r16, r15
3c128000 12 80000000  // lui r18, 0x8000
0240982a 13 00000001  // slt r19, r18, r0
0012a02b 14 00000001  // sltu r20, r0, r18
0012afc2 15 00000001  // srl r21, r18, 31
3416ffff 16 0000ffff  // ori r22, r0, 0xffff
26d78000 17 00007fff  // addiu r23, r22, -32768
02f6c026 18 00008000  // xor r24, r23, r22
0300c827 19 ffff7fff  // nor r25, r24, r0
0336d024 1a 00007fff  // and r26, r25, r22
001ad823 1b ffff8001  // subu r27, r0, r26
001be400 1c 80010000  // sll r28, r27, 16
039be821 1d 80008001  // addu r29, r28, r27
0000000c 00 00000000  // syscall, unsupported
03a1f021 1e 80008006  // addu r30, r29, r1
03c0f825 1f 80008006  // or r31, r30, r0

//--- compile.f
core_pkg.sv
instr_queue.sv
regfile.sv
decode_and_issue.sv
instr_exec.sv
cpu_core.sv
tb_cpu_core.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_cpu_core
FILELIST = compile.f
LOG      = sim.log

SRCS := $(shell cat $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN) cpu_stim.txt
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
